//--- hdl/isa_pkg.sv
package isa_pkg;
	localparam int instr_width = 24;
	localparam int opcode_width = 4;
	localparam int control_width = 16;
	localparam int alu_op_width = 4;
	localparam int wb_sel_width = 2;

	// li reuses the rs1 and rs2 bits of the instruction as its immediate
	localparam int opcode_lsb = 20;
	localparam int rd_lsb = 15;
	localparam int rs1_lsb = 10;
	localparam int rs2_lsb = 5;
	localparam int imm_lsb = 5;
	localparam int imm_width = 10;

	typedef logic [instr_width-1:0] instr_t;
	typedef logic [control_width-1:0] control_t;
	typedef logic [alu_op_width-1:0] alu_op_t;
	typedef logic [alu_op_width-1:0] vector_alu_op_t;
	typedef logic [wb_sel_width-1:0] scalar_wb_sel_t;
	typedef logic [wb_sel_width-1:0] vector_wb_sel_t;

	typedef enum logic [opcode_width-1:0] {
		op_nop = 4'd0,
		op_li = 4'd1,
		op_add = 4'd2,
		op_sub = 4'd3,
		op_and = 4'd4,
		op_or = 4'd5,
		op_xor = 4'd6,
		op_shl = 4'd7,
		op_vadd = 4'd8,
		op_vsub = 4'd9,
		op_vand = 4'd10,
		op_vor = 4'd11,
		op_vxor = 4'd12,
		op_splat = 4'd13,
		op_lanesum = 4'd14
	} opcode_t; // code 15 is reserved

	// control word fields run from the top bit down with bits 1:0 spare
	localparam int ctl_wre = 15;
	localparam int ctl_vector_wre = 14;
	localparam int ctl_scalar_sel_lsb = 12;
	localparam int ctl_vector_sel_lsb = 10;
	localparam int ctl_alu_op_lsb = 6;
	localparam int ctl_vector_alu_op_lsb = 2;
	localparam control_t control_nop = '0;

	localparam alu_op_t alu_pass_b = 4'd0;
	localparam alu_op_t alu_add = 4'd1;
	localparam alu_op_t alu_sub = 4'd2;
	localparam alu_op_t alu_and = 4'd3;
	localparam alu_op_t alu_or = 4'd4;
	localparam alu_op_t alu_xor = 4'd5;
	localparam alu_op_t alu_shl = 4'd6; // shift amount is b[3:0]

	localparam vector_alu_op_t valu_add = 4'd0;
	localparam vector_alu_op_t valu_sub = 4'd1;
	localparam vector_alu_op_t valu_and = 4'd2;
	localparam vector_alu_op_t valu_or = 4'd3;
	localparam vector_alu_op_t valu_xor = 4'd4;

	localparam scalar_wb_sel_t wb_scalar_alu = 2'd0;
	localparam scalar_wb_sel_t wb_lane_sum = 2'd1;
	localparam vector_wb_sel_t wb_vector_alu = 2'd0;
	localparam vector_wb_sel_t wb_splat = 2'd1;
endpackage

//--- hdl/datapath_pkg.sv
package datapath_pkg;
	localparam int word_width = 16;
	localparam int lane_width = 16;
	localparam int lane_count = 8;
	localparam int vector_width = lane_width * lane_count;
	localparam int reg_addr_width = 5;

	typedef logic [word_width-1:0] word_t;
	typedef logic [lane_width-1:0] lane_t; // lane i sits at bits 16i+15 down to 16i
	typedef logic [vector_width-1:0] vector_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;
endpackage

//--- hdl/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
	input logic instr_valid,
	input isa_pkg::instr_t instr,
	input datapath_pkg::word_t rd_scalar_a,
	input datapath_pkg::word_t rd_scalar_b,
	input datapath_pkg::vector_t rd_vector_a,
	input datapath_pkg::vector_t rd_vector_b,
	input logic ex_wre,
	input logic ex_vector_wre,
	input datapath_pkg::reg_addr_t ex_rd,
	input datapath_pkg::word_t ex_scalar,
	input datapath_pkg::vector_t ex_vector,
	output datapath_pkg::reg_addr_t rs1,
	output datapath_pkg::reg_addr_t rs2,
	output datapath_pkg::reg_addr_t rd,
	output isa_pkg::control_t control,
	output datapath_pkg::word_t src_a,
	output datapath_pkg::word_t src_b,
	output datapath_pkg::vector_t src_a_vector,
	output datapath_pkg::vector_t src_b_vector
);

	isa_pkg::opcode_t opcode;
	logic wre;
	logic vector_wre;
	isa_pkg::scalar_wb_sel_t scalar_wb_sel;
	isa_pkg::vector_wb_sel_t vector_wb_sel;
	isa_pkg::alu_op_t alu_op;
	isa_pkg::vector_alu_op_t vector_alu_op;
	datapath_pkg::word_t immediate;

	assign opcode = isa_pkg::opcode_t'(instr[isa_pkg::opcode_lsb +: isa_pkg::opcode_width]);
	assign rd = instr[isa_pkg::rd_lsb +: datapath_pkg::reg_addr_width];
	assign rs1 = instr[isa_pkg::rs1_lsb +: datapath_pkg::reg_addr_width];
	assign rs2 = instr[isa_pkg::rs2_lsb +: datapath_pkg::reg_addr_width];
	assign immediate = datapath_pkg::word_t'(instr[isa_pkg::imm_lsb +: isa_pkg::imm_width]);

	always_comb begin
		wre = 1'b0;
		vector_wre = 1'b0;
		scalar_wb_sel = isa_pkg::wb_scalar_alu;
		vector_wb_sel = isa_pkg::wb_vector_alu;
		case (opcode)
			isa_pkg::op_li, isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
			isa_pkg::op_or, isa_pkg::op_xor, isa_pkg::op_shl: wre = 1'b1;
			isa_pkg::op_vadd, isa_pkg::op_vsub, isa_pkg::op_vand, isa_pkg::op_vor,
			isa_pkg::op_vxor: vector_wre = 1'b1;
			isa_pkg::op_splat: begin
				vector_wre = 1'b1;
				vector_wb_sel = isa_pkg::wb_splat;
			end
			isa_pkg::op_lanesum: begin
				wre = 1'b1;
				scalar_wb_sel = isa_pkg::wb_lane_sum;
			end
			default: ; // nop and the reserved code write nothing
		endcase
	end

	always_comb begin
		alu_op = isa_pkg::alu_pass_b; // li passes the immediate through b
		vector_alu_op = isa_pkg::valu_add;
		case (opcode)
			isa_pkg::op_add: alu_op = isa_pkg::alu_add;
			isa_pkg::op_sub: alu_op = isa_pkg::alu_sub;
			isa_pkg::op_and: alu_op = isa_pkg::alu_and;
			isa_pkg::op_or: alu_op = isa_pkg::alu_or;
			isa_pkg::op_xor: alu_op = isa_pkg::alu_xor;
			isa_pkg::op_shl: alu_op = isa_pkg::alu_shl;
			isa_pkg::op_vsub: vector_alu_op = isa_pkg::valu_sub;
			isa_pkg::op_vand: vector_alu_op = isa_pkg::valu_and;
			isa_pkg::op_vor: vector_alu_op = isa_pkg::valu_or;
			isa_pkg::op_vxor: vector_alu_op = isa_pkg::valu_xor;
			default: ;
		endcase
	end

	always_comb begin
		control = isa_pkg::control_nop; // an empty cycle becomes a bubble
		if (instr_valid) begin
			control[isa_pkg::ctl_wre] = wre;
			control[isa_pkg::ctl_vector_wre] = vector_wre;
			control[isa_pkg::ctl_scalar_sel_lsb +: isa_pkg::wb_sel_width] = scalar_wb_sel;
			control[isa_pkg::ctl_vector_sel_lsb +: isa_pkg::wb_sel_width] = vector_wb_sel;
			control[isa_pkg::ctl_alu_op_lsb +: isa_pkg::alu_op_width] = alu_op;
			control[isa_pkg::ctl_vector_alu_op_lsb +: isa_pkg::alu_op_width] = vector_alu_op;
		end
	end

	// the instruction one ahead has not reached the register file yet
	assign src_a = (ex_wre && ex_rd == rs1) ? ex_scalar : rd_scalar_a;
	assign src_b = (opcode == isa_pkg::op_li) ? immediate :
		(ex_wre && ex_rd == rs2) ? ex_scalar : rd_scalar_b;
	assign src_a_vector = (ex_vector_wre && ex_rd == rs1) ? ex_vector : rd_vector_a;
	assign src_b_vector = (ex_vector_wre && ex_rd == rs2) ? ex_vector : rd_vector_b;
endmodule

//--- hdl/register_files.sv
`timescale 1ns/1ns

module register_files #(
	parameter int reg_count = 32
) (
	input logic clk,
	input logic reset,
	input datapath_pkg::reg_addr_t rs1,
	input datapath_pkg::reg_addr_t rs2,
	input logic wre,
	input logic vector_wre,
	input datapath_pkg::reg_addr_t wd_addr,
	input datapath_pkg::word_t wd_scalar,
	input datapath_pkg::vector_t wd_vector,
	output datapath_pkg::word_t scalar_a,
	output datapath_pkg::word_t scalar_b,
	output datapath_pkg::vector_t vector_a,
	output datapath_pkg::vector_t vector_b
);

	datapath_pkg::word_t scalar_mem [reg_count];
	datapath_pkg::vector_t vector_mem [reg_count];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				scalar_mem[i] <= '0;
				vector_mem[i] <= '0;
			end
		end else begin
			if (wre)
				scalar_mem[wd_addr] <= wd_scalar;
			if (vector_wre)
				vector_mem[wd_addr] <= wd_vector; // same rd can carry both writes
		end
	end

	// reads see the array only, a write lands at the edge and shows next cycle
	assign scalar_a = scalar_mem[rs1];
	assign scalar_b = scalar_mem[rs2];
	assign vector_a = vector_mem[rs1];
	assign vector_b = vector_mem[rs2];
endmodule

//--- hdl/decode_execute_register.sv
`timescale 1ns/1ns

module decode_execute_register (
	input logic clk,
	input logic reset,
	input isa_pkg::control_t control_in,
	input datapath_pkg::word_t src_a_in,
	input datapath_pkg::word_t src_b_in,
	input datapath_pkg::vector_t src_a_vector_in,
	input datapath_pkg::vector_t src_b_vector_in,
	input datapath_pkg::reg_addr_t rs1_decode,
	input datapath_pkg::reg_addr_t rs2_decode,
	input datapath_pkg::reg_addr_t rd_decode,
	output logic wre_execute,
	output logic vector_wre_execute,
	output isa_pkg::scalar_wb_sel_t select_writeback_data_mux_execute,
	output isa_pkg::vector_wb_sel_t select_writeback_vector_data_mux_execute,
	output isa_pkg::alu_op_t alu_op_execute,
	output isa_pkg::vector_alu_op_t vector_alu_op_execute,
	output datapath_pkg::word_t src_a_out,
	output datapath_pkg::word_t src_b_out,
	output datapath_pkg::vector_t src_a_vector_out,
	output datapath_pkg::vector_t src_b_vector_out,
	output datapath_pkg::reg_addr_t rs1_execute,
	output datapath_pkg::reg_addr_t rs2_execute,
	output datapath_pkg::reg_addr_t rd_execute
);

	// all zero is a nop, so a reset pipeline writes nothing
	always_ff @(posedge clk) begin
		if (reset) begin
			wre_execute <= 1'b0;
			vector_wre_execute <= 1'b0;
			select_writeback_data_mux_execute <= '0;
			select_writeback_vector_data_mux_execute <= '0;
			alu_op_execute <= '0;
			vector_alu_op_execute <= '0;
			src_a_out <= '0;
			src_b_out <= '0;
			src_a_vector_out <= '0;
			src_b_vector_out <= '0;
			rs1_execute <= '0;
			rs2_execute <= '0;
			rd_execute <= '0;
		end else begin
			wre_execute <= control_in[isa_pkg::ctl_wre];
			vector_wre_execute <= control_in[isa_pkg::ctl_vector_wre];
			select_writeback_data_mux_execute <=
				control_in[isa_pkg::ctl_scalar_sel_lsb +: isa_pkg::wb_sel_width];
			select_writeback_vector_data_mux_execute <=
				control_in[isa_pkg::ctl_vector_sel_lsb +: isa_pkg::wb_sel_width];
			alu_op_execute <= control_in[isa_pkg::ctl_alu_op_lsb +: isa_pkg::alu_op_width];
			vector_alu_op_execute <=
				control_in[isa_pkg::ctl_vector_alu_op_lsb +: isa_pkg::alu_op_width];
			src_a_out <= src_a_in;
			src_b_out <= src_b_in;
			src_a_vector_out <= src_a_vector_in;
			src_b_vector_out <= src_b_vector_in;
			rs1_execute <= rs1_decode;
			rs2_execute <= rs2_decode;
			rd_execute <= rd_decode;
		end
	end
endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
	input logic clk,
	input logic reset,
	input logic wre,
	input logic vector_wre,
	input isa_pkg::scalar_wb_sel_t scalar_wb_sel,
	input isa_pkg::vector_wb_sel_t vector_wb_sel,
	input isa_pkg::alu_op_t alu_op,
	input isa_pkg::vector_alu_op_t vector_alu_op,
	input datapath_pkg::word_t src_a,
	input datapath_pkg::word_t src_b,
	input datapath_pkg::vector_t src_a_vector,
	input datapath_pkg::vector_t src_b_vector,
	input datapath_pkg::reg_addr_t rd,
	output logic ex_wre,
	output logic ex_vector_wre,
	output datapath_pkg::reg_addr_t ex_rd,
	output datapath_pkg::word_t ex_scalar,
	output datapath_pkg::vector_t ex_vector,
	output logic wb_wre,
	output logic wb_vector_wre,
	output datapath_pkg::reg_addr_t wb_rd,
	output datapath_pkg::word_t wb_scalar,
	output datapath_pkg::vector_t wb_vector,
	output logic result_valid
);

	datapath_pkg::word_t alu_result;
	datapath_pkg::word_t lane_sum;
	datapath_pkg::vector_t vector_result;
	datapath_pkg::vector_t splat_result;

	always_comb begin
		case (alu_op)
			isa_pkg::alu_add: alu_result = src_a + src_b;
			isa_pkg::alu_sub: alu_result = src_a - src_b;
			isa_pkg::alu_and: alu_result = src_a & src_b;
			isa_pkg::alu_or: alu_result = src_a | src_b;
			isa_pkg::alu_xor: alu_result = src_a ^ src_b;
			isa_pkg::alu_shl: alu_result = src_a << src_b[3:0];
			default: alu_result = src_b;
		endcase
	end

	// lanes never carry into each other, each wraps on its own
	always_comb begin
		datapath_pkg::lane_t lane_a;
		datapath_pkg::lane_t lane_b;
		datapath_pkg::lane_t lane_y;
		vector_result = '0;
		for (int i = 0; i < datapath_pkg::lane_count; i++) begin
			lane_a = src_a_vector[i*datapath_pkg::lane_width +: datapath_pkg::lane_width];
			lane_b = src_b_vector[i*datapath_pkg::lane_width +: datapath_pkg::lane_width];
			case (vector_alu_op)
				isa_pkg::valu_sub: lane_y = lane_a - lane_b;
				isa_pkg::valu_and: lane_y = lane_a & lane_b;
				isa_pkg::valu_or: lane_y = lane_a | lane_b;
				isa_pkg::valu_xor: lane_y = lane_a ^ lane_b;
				default: lane_y = lane_a + lane_b;
			endcase
			vector_result[i*datapath_pkg::lane_width +: datapath_pkg::lane_width] = lane_y;
		end
	end

	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < datapath_pkg::lane_count; i++)
			lane_sum = lane_sum + src_a_vector[i*datapath_pkg::lane_width +: datapath_pkg::lane_width];
	end

	assign splat_result = {datapath_pkg::lane_count{src_a}};

	// also fed back to decode for the instruction right behind
	assign ex_wre = wre;
	assign ex_vector_wre = vector_wre;
	assign ex_rd = rd;
	assign ex_scalar = (scalar_wb_sel == isa_pkg::wb_lane_sum) ? lane_sum : alu_result;
	assign ex_vector = (vector_wb_sel == isa_pkg::wb_splat) ? splat_result : vector_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_wre <= 1'b0;
			wb_vector_wre <= 1'b0;
		end else begin
			wb_wre <= ex_wre;
			wb_vector_wre <= ex_vector_wre;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= ex_rd;
		wb_scalar <= ex_scalar;
		wb_vector <= ex_vector;
	end

	assign result_valid = wb_wre | wb_vector_wre;
endmodule

//--- hdl/simd_core.sv
`timescale 1ns/1ns

module simd_core #(
	parameter int reg_count = 32
) (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input isa_pkg::instr_t instr,
	output logic result_valid,
	output logic result_scalar_wre,
	output logic result_vector_wre,
	output datapath_pkg::reg_addr_t result_rd,
	output datapath_pkg::word_t result_scalar,
	output datapath_pkg::vector_t result_vector
);

	datapath_pkg::reg_addr_t rs1;
	datapath_pkg::reg_addr_t rs2;
	datapath_pkg::reg_addr_t rd;
	isa_pkg::control_t control;
	datapath_pkg::word_t src_a;
	datapath_pkg::word_t src_b;
	datapath_pkg::vector_t src_a_vector;
	datapath_pkg::vector_t src_b_vector;
	datapath_pkg::word_t rf_scalar_a;
	datapath_pkg::word_t rf_scalar_b;
	datapath_pkg::vector_t rf_vector_a;
	datapath_pkg::vector_t rf_vector_b;

	logic wre_e;
	logic vector_wre_e;
	isa_pkg::scalar_wb_sel_t scalar_wb_sel_e;
	isa_pkg::vector_wb_sel_t vector_wb_sel_e;
	isa_pkg::alu_op_t alu_op_e;
	isa_pkg::vector_alu_op_t vector_alu_op_e;
	datapath_pkg::word_t src_a_e;
	datapath_pkg::word_t src_b_e;
	datapath_pkg::vector_t src_a_vector_e;
	datapath_pkg::vector_t src_b_vector_e;
	datapath_pkg::reg_addr_t rd_e;

	logic ex_wre;
	logic ex_vector_wre;
	datapath_pkg::reg_addr_t ex_rd;
	datapath_pkg::word_t ex_scalar;
	datapath_pkg::vector_t ex_vector;

	decode_unit decode_unit_inst (
		.instr_valid(instr_valid),
		.instr(instr),
		.rd_scalar_a(rf_scalar_a),
		.rd_scalar_b(rf_scalar_b),
		.rd_vector_a(rf_vector_a),
		.rd_vector_b(rf_vector_b),
		.ex_wre(ex_wre),
		.ex_vector_wre(ex_vector_wre),
		.ex_rd(ex_rd),
		.ex_scalar(ex_scalar),
		.ex_vector(ex_vector),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.control(control),
		.src_a(src_a),
		.src_b(src_b),
		.src_a_vector(src_a_vector),
		.src_b_vector(src_b_vector)
	);

	// written on the same edge that loads the writeback register
	register_files #(
		.reg_count(reg_count)
	) register_files_inst (
		.clk(clk),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.wre(ex_wre),
		.vector_wre(ex_vector_wre),
		.wd_addr(ex_rd),
		.wd_scalar(ex_scalar),
		.wd_vector(ex_vector),
		.scalar_a(rf_scalar_a),
		.scalar_b(rf_scalar_b),
		.vector_a(rf_vector_a),
		.vector_b(rf_vector_b)
	);

	decode_execute_register decode_execute_register_inst (
		.clk(clk),
		.reset(reset),
		.control_in(control),
		.src_a_in(src_a),
		.src_b_in(src_b),
		.src_a_vector_in(src_a_vector),
		.src_b_vector_in(src_b_vector),
		.rs1_decode(rs1),
		.rs2_decode(rs2),
		.rd_decode(rd),
		.wre_execute(wre_e),
		.vector_wre_execute(vector_wre_e),
		.select_writeback_data_mux_execute(scalar_wb_sel_e),
		.select_writeback_vector_data_mux_execute(vector_wb_sel_e),
		.alu_op_execute(alu_op_e),
		.vector_alu_op_execute(vector_alu_op_e),
		.src_a_out(src_a_e),
		.src_b_out(src_b_e),
		.src_a_vector_out(src_a_vector_e),
		.src_b_vector_out(src_b_vector_e),
		.rs1_execute(), // forwarding matches in decode
		.rs2_execute(),
		.rd_execute(rd_e)
	);

	execute_unit execute_unit_inst (
		.clk(clk),
		.reset(reset),
		.wre(wre_e),
		.vector_wre(vector_wre_e),
		.scalar_wb_sel(scalar_wb_sel_e),
		.vector_wb_sel(vector_wb_sel_e),
		.alu_op(alu_op_e),
		.vector_alu_op(vector_alu_op_e),
		.src_a(src_a_e),
		.src_b(src_b_e),
		.src_a_vector(src_a_vector_e),
		.src_b_vector(src_b_vector_e),
		.rd(rd_e),
		.ex_wre(ex_wre),
		.ex_vector_wre(ex_vector_wre),
		.ex_rd(ex_rd),
		.ex_scalar(ex_scalar),
		.ex_vector(ex_vector),
		.wb_wre(result_scalar_wre),
		.wb_vector_wre(result_vector_wre),
		.wb_rd(result_rd),
		.wb_scalar(result_scalar),
		.wb_vector(result_vector),
		.result_valid(result_valid)
	);
endmodule

//--- sim/simd_core_tb.sv
`timescale 1ns/1ns

module simd_core_tb;
	typedef struct packed {
		logic scalar_wre;
		logic vector_wre;
		datapath_pkg::reg_addr_t rd;
		datapath_pkg::word_t scalar;
		datapath_pkg::vector_t vector;
		int cycle; // cycle count at which the write must show up
	} expected_t;

	logic clk;
	logic reset;
	logic instr_valid;
	isa_pkg::instr_t instr;
	logic result_valid;
	logic result_scalar_wre;
	logic result_vector_wre;
	datapath_pkg::reg_addr_t result_rd;
	datapath_pkg::word_t result_scalar;
	datapath_pkg::vector_t result_vector;

	datapath_pkg::word_t model_scalar [32];
	datapath_pkg::vector_t model_vector [32];
	expected_t expected_q [$];
	int cycle_count = 0;
	int issued_count = 0;
	int mismatch_count = 0;
	int other_error_count = 0;

	simd_core #(
		.reg_count(32)
	) simd_core_inst (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.result_valid(result_valid),
		.result_scalar_wre(result_scalar_wre),
		.result_vector_wre(result_vector_wre),
		.result_rd(result_rd),
		.result_scalar(result_scalar),
		.result_vector(result_vector)
	);

	always #4 clk = ~clk;

	// every driven cycle raises the limit, so only a stuck wait runs into it
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > issued_count + 200) begin
			$display("error: run passed %0d cycles without finishing", issued_count + 200);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic compare_word(input datapath_pkg::word_t actual,
		input datapath_pkg::word_t expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic compare_vector(input datapath_pkg::vector_t actual,
		input datapath_pkg::vector_t expected, input string what);
		for (int i = 0; i < datapath_pkg::lane_count; i++) begin
			if (actual[i*16 +: 16] !== expected[i*16 +: 16]) begin
				$display("mismatch at %0t: %s lane %0d got %h expected %h", $time, what, i,
					actual[i*16 +: 16], expected[i*16 +: 16]);
				mismatch_count++;
			end
		end
	endtask

	task automatic compare_addr(input datapath_pkg::reg_addr_t actual,
		input datapath_pkg::reg_addr_t expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic compare_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic compare_cycle(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	// outputs change on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin : result_monitor
		expected_t head;
		if (result_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				$display("error at %0t: result_valid went high with no write outstanding", $time);
				other_error_count++;
			end else begin
				head = expected_q.pop_front();
				compare_cycle(cycle_count, head.cycle, "result cycle");
				compare_flag(result_scalar_wre, head.scalar_wre, "scalar write enable");
				compare_flag(result_vector_wre, head.vector_wre, "vector write enable");
				compare_addr(result_rd, head.rd, "result rd");
				if (head.scalar_wre)
					compare_word(result_scalar, head.scalar, "scalar result");
				if (head.vector_wre)
					compare_vector(result_vector, head.vector, "vector result");
			end
		end else begin
			if (reset === 1'b0) begin
				compare_flag(result_scalar_wre, 1'b0, "scalar write enable without result_valid");
				compare_flag(result_vector_wre, 1'b0, "vector write enable without result_valid");
			end
			if (expected_q.size() != 0 && expected_q[0].cycle <= cycle_count) begin
				$display("error at %0t: the write to r%0d never showed up", $time,
					expected_q[0].rd);
				other_error_count++;
				head = expected_q.pop_front();
			end
		end
	end

	function automatic datapath_pkg::word_t lane_result(input int kind,
		input datapath_pkg::word_t x, input datapath_pkg::word_t y);
		case (kind)
			0: return x + y;
			1: return x - y;
			2: return x & y;
			3: return x | y;
			default: return x ^ y;
		endcase
	endfunction

	// reference ISA model that runs one instruction at a time in program order
	task automatic model_instr(input isa_pkg::instr_t word, output expected_t entry);
		logic [3:0] op;
		int rd;
		datapath_pkg::word_t a;
		datapath_pkg::word_t b;
		datapath_pkg::vector_t va;
		datapath_pkg::vector_t vb;
		op = word[23:20];
		rd = word[19:15];
		a = model_scalar[word[14:10]];
		b = model_scalar[word[9:5]];
		va = model_vector[word[14:10]];
		vb = model_vector[word[9:5]];
		entry = '0;
		entry.rd = word[19:15];
		if (op == isa_pkg::op_li) begin
			entry.scalar_wre = 1'b1;
			entry.scalar = datapath_pkg::word_t'(word[14:5]);
		end else if (op >= isa_pkg::op_add && op <= isa_pkg::op_xor) begin
			entry.scalar_wre = 1'b1;
			entry.scalar = lane_result(int'(op) - int'(isa_pkg::op_add), a, b);
		end else if (op == isa_pkg::op_shl) begin
			entry.scalar_wre = 1'b1;
			entry.scalar = a << b[3:0];
		end else if (op >= isa_pkg::op_vadd && op <= isa_pkg::op_vxor) begin
			entry.vector_wre = 1'b1;
			for (int i = 0; i < 8; i++)
				entry.vector[i*16 +: 16] = lane_result(int'(op) - int'(isa_pkg::op_vadd),
					va[i*16 +: 16], vb[i*16 +: 16]);
		end else if (op == isa_pkg::op_splat) begin
			entry.vector_wre = 1'b1;
			for (int i = 0; i < 8; i++)
				entry.vector[i*16 +: 16] = a;
		end else if (op == isa_pkg::op_lanesum) begin
			entry.scalar_wre = 1'b1;
			for (int i = 0; i < 8; i++)
				entry.scalar = entry.scalar + va[i*16 +: 16];
		end
		if (entry.scalar_wre)
			model_scalar[rd] = entry.scalar;
		if (entry.vector_wre)
			model_vector[rd] = entry.vector;
	endtask

	task automatic issue_instr(input isa_pkg::instr_t word);
		expected_t entry;
		@(negedge clk);
		instr_valid = 1'b1;
		instr = word;
		issued_count++;
		model_instr(word, entry);
		if (entry.scalar_wre || entry.vector_wre) begin
			entry.cycle = cycle_count + 2; // fixed two-cycle latency
			expected_q.push_back(entry);
		end
	endtask

	task automatic issue_op(input logic [3:0] op, input int rd, input int rs1, input int rs2);
		issue_instr({op, datapath_pkg::reg_addr_t'(rd), datapath_pkg::reg_addr_t'(rs1),
			datapath_pkg::reg_addr_t'(rs2), 5'd0});
	endtask

	task automatic issue_li(input int rd, input logic [9:0] imm);
		issue_instr({isa_pkg::op_li, datapath_pkg::reg_addr_t'(rd), imm, 5'd0});
	endtask

	// the bus carries junk while instr_valid is low
	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(negedge clk);
			instr_valid = 1'b0;
			instr = isa_pkg::instr_t'($urandom);
			issued_count++;
		end
	endtask

	task automatic drain_pipeline();
		idle_cycles(1);
		while (expected_q.size() != 0)
			@(negedge clk);
	endtask

	function automatic logic [9:0] random_imm();
		return 10'($urandom);
	endfunction

	task automatic reset_and_li();
		compare_flag(result_valid, 1'b0, "result_valid after reset");
		idle_cycles(5);
		issue_li(1, 10'h3ff);
		issue_li(2, 10'h000);
		issue_li(3, random_imm());
		issue_li(31, random_imm());
		idle_cycles(2);
		issue_li(4, random_imm());
		drain_pipeline();
	endtask

	task automatic scalar_alu_ops();
		issue_li(5, random_imm());
		issue_li(6, random_imm());
		issue_op(isa_pkg::op_add, 7, 5, 6);
		issue_op(isa_pkg::op_sub, 8, 5, 6);
		issue_op(isa_pkg::op_and, 9, 5, 6);
		issue_op(isa_pkg::op_or, 10, 5, 6);
		issue_op(isa_pkg::op_xor, 11, 5, 6);
		issue_li(12, random_imm());
		issue_op(isa_pkg::op_shl, 13, 5, 12);
		issue_li(14, 10'h3ff);
		issue_li(15, 10'd6);
		issue_op(isa_pkg::op_shl, 16, 14, 15); // 16'hffc0
		issue_op(isa_pkg::op_add, 17, 16, 16); // carries out of bit 15
		issue_op(isa_pkg::op_sub, 18, 6, 16);
		drain_pipeline();
	endtask

	task automatic vector_alu_ops();
		issue_li(1, random_imm());
		issue_op(isa_pkg::op_splat, 1, 1, 0);
		issue_li(2, random_imm());
		issue_op(isa_pkg::op_splat, 2, 2, 0);
		issue_li(3, 10'h3ff);
		issue_li(4, 10'd6);
		issue_op(isa_pkg::op_shl, 3, 3, 4);
		issue_op(isa_pkg::op_splat, 3, 3, 0);
		issue_op(isa_pkg::op_vadd, 4, 1, 2);
		issue_op(isa_pkg::op_vsub, 5, 1, 2);
		issue_op(isa_pkg::op_vand, 6, 1, 2);
		issue_op(isa_pkg::op_vor, 7, 1, 2);
		issue_op(isa_pkg::op_vxor, 8, 1, 2);
		issue_op(isa_pkg::op_vadd, 9, 3, 3);
		issue_op(isa_pkg::op_vsub, 10, 2, 3);
		drain_pipeline();
	endtask

	task automatic lanesum_and_splat();
		issue_li(20, random_imm());
		issue_op(isa_pkg::op_splat, 20, 20, 0);
		issue_op(isa_pkg::op_lanesum, 21, 20, 0);
		issue_li(22, random_imm());
		issue_op(isa_pkg::op_splat, 22, 22, 0);
		issue_op(isa_pkg::op_vadd, 23, 20, 22);
		issue_op(isa_pkg::op_lanesum, 23, 23, 0);
		issue_op(isa_pkg::op_lanesum, 24, 9, 0);
		issue_op(isa_pkg::op_splat, 24, 23, 0);
		issue_op(isa_pkg::op_lanesum, 25, 24, 0);
		drain_pipeline();
	endtask

	// gap 0 reads through forwarding, gap 1 and up through the register file
	task automatic dependency_chain(input int gap);
		issue_li(26, random_imm());
		idle_cycles(gap);
		issue_op(isa_pkg::op_add, 27, 26, 26);
		idle_cycles(gap);
		issue_op(isa_pkg::op_sub, 28, 27, 26);
		idle_cycles(gap);
		issue_op(isa_pkg::op_shl, 29, 28, 27);
		idle_cycles(gap);
		issue_op(isa_pkg::op_splat, 26, 29, 0);
		idle_cycles(gap);
		issue_op(isa_pkg::op_vadd, 27, 26, 26);
		idle_cycles(gap);
		issue_op(isa_pkg::op_vxor, 28, 27, 26);
		idle_cycles(gap);
		issue_op(isa_pkg::op_lanesum, 30, 28, 0);
		idle_cycles(gap);
		issue_op(isa_pkg::op_splat, 29, 30, 0);
		idle_cycles(gap);
		issue_op(isa_pkg::op_xor, 30, 30, 29);
		drain_pipeline();
	endtask

	task automatic nop_handling();
		issue_li(11, random_imm());
		issue_op(4'd15, 11, 1, 2); // reserved code
		issue_op(isa_pkg::op_nop, 11, 3, 4);
		idle_cycles(3);
		issue_op(isa_pkg::op_add, 12, 11, 11);
		issue_op(4'd15, 12, 12, 12);
		issue_op(isa_pkg::op_or, 13, 12, 11);
		issue_li(14, random_imm());
		issue_op(isa_pkg::op_nop, 14, 0, 0);
		issue_op(isa_pkg::op_add, 15, 14, 14);
		idle_cycles(2);
		issue_op(isa_pkg::op_splat, 15, 15, 0);
		drain_pipeline();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		void'($urandom(32'h76a0_72e5));
		for (int i = 0; i < 32; i++) begin
			model_scalar[i] = '0;
			model_vector[i] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		reset_and_li();
		scalar_alu_ops();
		vector_alu_ops();
		lanesum_and_splat();
		dependency_chain(0);
		dependency_chain(1);
		dependency_chain(2);
		nop_handling();
		idle_cycles(4);

		$display("run complete: %0d mismatches, %0d other errors", mismatch_count,
			other_error_count);
		if (mismatch_count + other_error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end
endmodule

//--- tb.f
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/decode_unit.sv
hdl/register_files.sv
hdl/decode_execute_register.sv
hdl/execute_unit.sv
hdl/simd_core.sv
sim/simd_core_tb.sv
